//--- Makefile
TOP = tb_poly_mul

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f verilog.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- gf_mul.sv
`timescale 1ns/10ps
`default_nettype none

module gf_mul (
	input  wire gf_poly_pkg::coef_t a,
	input  wire gf_poly_pkg::coef_t b,
	output gf_poly_pkg::coef_t      p
);

	gf_poly_pkg::coef_t acc; // running sum of shifted copies of a
	gf_poly_pkg::coef_t sh;  // a * x^n mod field poly

	// shift-and-add, reducing every step so sh never leaves the field
	always_comb begin
		acc = '0;
		sh = a;
		for (int n = 0; n < gf_poly_pkg::M; n++) begin
			if (b[n])
				acc = acc ^ sh;
			// times x, fold the overflow bit back in
			if (sh[gf_poly_pkg::M-1])
				sh = (sh << 1) ^ gf_poly_pkg::FIELD_POLY;
			else
				sh = sh << 1;
		end
	end

	assign p = acc;

endmodule

`default_nettype wire

//--- gf_poly_pkg.sv
`default_nettype none

package gf_poly_pkg;

	// ----------------------------------------------------------------------
	// field and word geometry
	// ----------------------------------------------------------------------
	localparam int M = 8;                 // bits per field coefficient
	localparam int K = 5;                 // coefficients packed per word
	localparam int DEPTH = 4;             // words per operand polynomial
	localparam int RAM_WORDS = 2 * DEPTH; // A and B share one RAM, C fills one
	localparam int WORD_W = K * M;
	localparam int ADDR_W = $clog2(RAM_WORDS);

	// x^8 + x^4 + x^3 + x + 1, top bit implied
	localparam logic [M-1:0] FIELD_POLY = 8'h1B;

	// controller states
	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_CLEAR = 2'd1;
	localparam logic [1:0] S_PAIR  = 2'd2;

	// ----------------------------------------------------------------------
	// shared types
	// ----------------------------------------------------------------------
	typedef logic [M-1:0] coef_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// one memory word, seen raw or as K coefficients (index 0 = lowest degree)
	typedef union packed {
		logic [WORD_W-1:0] flat;
		coef_t [K-1:0]     coef;
	} poly_word_u;

	// one RAM port request
	typedef struct packed {
		logic       we;
		addr_t      addr;
		poly_word_u wdata;
	} mem_req_t;

	// word product, hi carries the degrees that spill past K-1
	typedef struct packed {
		poly_word_u hi;
		poly_word_u lo;
	} prod_t;

endpackage

`default_nettype wire

//--- mul_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module mul_ctrl (
	input  wire                          clk,
	input  wire                          rst_b,
	input  wire                          start,
	input  wire gf_poly_pkg::mem_req_t   load,
	input  wire gf_poly_pkg::addr_t      rd_addr,
	output gf_poly_pkg::mem_req_t        op_a,
	output gf_poly_pkg::mem_req_t        op_b,
	output gf_poly_pkg::mem_req_t        acc_a,
	output gf_poly_pkg::mem_req_t        acc_b,
	input  wire gf_poly_pkg::poly_word_u acc_rdata_a,
	input  wire gf_poly_pkg::poly_word_u acc_rdata_b,
	input  wire gf_poly_pkg::prod_t      prod,
	output logic                         busy,
	output logic                         done
);

	logic [1:0]          state;
	logic [1:0]          phase;   // step within one (i, j) pair
	gf_poly_pkg::addr_t  i;       // A word index
	gf_poly_pkg::addr_t  j;       // B word index
	gf_poly_pkg::addr_t  clr_cnt; // C word pair being zeroed
	gf_poly_pkg::addr_t  c_addr;  // low C word hit by the current pair

	logic last_clr;
	logic last_j;
	logic last_i;

	assign c_addr = i + j;
	assign last_clr = (clr_cnt == gf_poly_pkg::addr_t'(gf_poly_pkg::RAM_WORDS / 2 - 1));
	assign last_j = (j == gf_poly_pkg::addr_t'(gf_poly_pkg::DEPTH - 1));
	assign last_i = (i == gf_poly_pkg::addr_t'(gf_poly_pkg::DEPTH - 1));

	assign busy = (state != gf_poly_pkg::S_IDLE);

	// ----------------------------------------------------------------------
	// state, counters and done
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_b) begin
			state <= gf_poly_pkg::S_IDLE;
			phase <= '0;
			i <= '0;
			j <= '0;
			clr_cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				gf_poly_pkg::S_IDLE: begin
					if (start) begin
						state <= gf_poly_pkg::S_CLEAR;
						clr_cnt <= '0;
					end
				end

				gf_poly_pkg::S_CLEAR: begin
					clr_cnt <= clr_cnt + 1'b1;
					if (last_clr) begin
						state <= gf_poly_pkg::S_PAIR;
						phase <= '0;
						i <= '0;
						j <= '0;
					end
				end

				gf_poly_pkg::S_PAIR: begin
					phase <= phase + 1'b1; // wraps to 0 for the next pair
					if (phase == 2'd3) begin
						if (last_j) begin
							j <= '0;
							if (last_i) begin
								// last accumulate lands on this edge
								i <= '0;
								state <= gf_poly_pkg::S_IDLE;
								done <= 1'b1;
							end else begin
								i <= i + 1'b1;
							end
						end else begin
							j <= j + 1'b1;
						end
					end
				end

				default: state <= gf_poly_pkg::S_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// RAM port requests
	// ----------------------------------------------------------------------
	always_comb begin
		op_a = '0;
		op_b = '0;
		acc_a = '0;
		acc_b = '0;
		case (state)
			gf_poly_pkg::S_IDLE: begin
				op_b = load;           // host fills A and B
				acc_a.addr = rd_addr;  // host reads C
			end

			gf_poly_pkg::S_CLEAR: begin
				// zero two C words per cycle with data left at '0
				acc_a.we = 1'b1;
				acc_a.addr = clr_cnt << 1;
				acc_b.we = 1'b1;
				acc_b.addr = (clr_cnt << 1) | gf_poly_pkg::addr_t'(1);
			end

			gf_poly_pkg::S_PAIR: begin
				// operand addresses held for the whole pair so prod is
				// still this pair's product in the write phase
				op_a.addr = i;
				op_b.addr = gf_poly_pkg::addr_t'(gf_poly_pkg::DEPTH) + j;
				acc_a.addr = c_addr;
				acc_b.addr = c_addr + 1'b1;
				if (phase == 2'd3) begin
					acc_a.we = 1'b1;
					acc_a.wdata.flat = acc_rdata_a.flat ^ prod.lo.flat;
					acc_b.we = 1'b1;
					acc_b.wdata.flat = acc_rdata_b.flat ^ prod.hi.flat;
				end
			end

			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- poly_mul_top.sv
`timescale 1ns/10ps
`default_nettype none

module poly_mul_top (
	input  wire                          clk,
	input  wire                          rst_b,
	input  wire                          start,
	input  wire gf_poly_pkg::mem_req_t   load,
	input  wire gf_poly_pkg::addr_t      rd_addr,
	output gf_poly_pkg::poly_word_u      rd_data,
	output logic                         busy,
	output logic                         done
);

	gf_poly_pkg::mem_req_t   op_a;
	gf_poly_pkg::mem_req_t   op_b;
	gf_poly_pkg::mem_req_t   acc_a;
	gf_poly_pkg::mem_req_t   acc_b;
	gf_poly_pkg::poly_word_u op_rdata_a;  // A word i
	gf_poly_pkg::poly_word_u op_rdata_b;  // B word j
	gf_poly_pkg::poly_word_u acc_rdata_a;
	gf_poly_pkg::poly_word_u acc_rdata_b;
	gf_poly_pkg::prod_t      prod;

	mul_ctrl u_ctrl (
		.clk         (clk),
		.rst_b       (rst_b),
		.start       (start),
		.load        (load),
		.rd_addr     (rd_addr),
		.op_a        (op_a),
		.op_b        (op_b),
		.acc_a       (acc_a),
		.acc_b       (acc_b),
		.acc_rdata_a (acc_rdata_a),
		.acc_rdata_b (acc_rdata_b),
		.prod        (prod),
		.busy        (busy),
		.done        (done)
	);

	// A at 0..DEPTH-1, B at DEPTH..2*DEPTH-1
	word_ram u_op_ram (
		.clk     (clk),
		.port_a  (op_a),
		.port_b  (op_b),
		.rdata_a (op_rdata_a),
		.rdata_b (op_rdata_b)
	);

	word_ram u_acc_ram (
		.clk     (clk),
		.port_a  (acc_a),
		.port_b  (acc_b),
		.rdata_a (acc_rdata_a),
		.rdata_b (acc_rdata_b)
	);

	word_mul u_word_mul (
		.clk  (clk),
		.a    (op_rdata_a),
		.b    (op_rdata_b),
		.prod (prod)
	);

	assign rd_data = acc_rdata_a; // host read shares C port a

endmodule

`default_nettype wire

//--- tb_poly_mul.sv
`timescale 1ns/10ps
`default_nettype none

module tb_poly_mul;

	localparam int PERIOD = 8;
	// start to done, upper bound
	localparam int RUN_CYCLES = gf_poly_pkg::RAM_WORDS / 2
		+ 4 * gf_poly_pkg::DEPTH * gf_poly_pkg::DEPTH + 1;
	localparam int NUM_RUNS = 8; // starts issued over all tests
	localparam int WATCHDOG_CYCLES = NUM_RUNS * (RUN_CYCLES + 6 * gf_poly_pkg::RAM_WORDS)
		+ 2 * RUN_CYCLES + 200;

	logic                    clk;
	logic                    rst_b;
	logic                    start;
	gf_poly_pkg::mem_req_t   load;
	gf_poly_pkg::addr_t      rd_addr;
	gf_poly_pkg::poly_word_u rd_data;
	logic                    busy;
	logic                    done;

	int errors;
	int checks;

	gf_poly_pkg::poly_word_u a_words [gf_poly_pkg::DEPTH];
	gf_poly_pkg::poly_word_u b_words [gf_poly_pkg::DEPTH];
	gf_poly_pkg::poly_word_u c_model [gf_poly_pkg::RAM_WORDS]; // expected C

	poly_mul_top u_dut (
		.clk     (clk),
		.rst_b   (rst_b),
		.start   (start),
		.load    (load),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.busy    (busy),
		.done    (done)
	);

	bind poly_mul_top tb_poly_mul_asserts u_asserts (
		.clk   (clk),
		.rst_b (rst_b),
		.busy  (busy),
		.done  (done)
	);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	// watchdog
	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------
	// GF(2^8) product, one bit of y per step
	function automatic gf_poly_pkg::coef_t field_mul(input gf_poly_pkg::coef_t x,
		input gf_poly_pkg::coef_t y);
		gf_poly_pkg::coef_t r;
		gf_poly_pkg::coef_t s;
		logic               carry;
		r = '0;
		s = x;
		for (int n = 0; n < gf_poly_pkg::M; n++) begin
			if (y[n])
				r = r ^ s;
			carry = s[gf_poly_pkg::M-1];
			s = s << 1;
			if (carry)
				s = s ^ gf_poly_pkg::FIELD_POLY; // x^8 folds back
		end
		return r;
	endfunction

	// schoolbook, degree w*K+k is word w coef k
	task automatic model_product;
		int dw;
		for (int w = 0; w < gf_poly_pkg::RAM_WORDS; w++)
			c_model[w] = '0;
		for (int du = 0; du < gf_poly_pkg::DEPTH * gf_poly_pkg::K; du++) begin
			for (int dv = 0; dv < gf_poly_pkg::DEPTH * gf_poly_pkg::K; dv++) begin
				dw = du + dv;
				c_model[dw / gf_poly_pkg::K].coef[dw % gf_poly_pkg::K] ^= field_mul(
					a_words[du / gf_poly_pkg::K].coef[du % gf_poly_pkg::K],
					b_words[dv / gf_poly_pkg::K].coef[dv % gf_poly_pkg::K]);
			end
		end
	endtask

	function automatic gf_poly_pkg::poly_word_u random_word();
		gf_poly_pkg::poly_word_u w;
		for (int k = 0; k < gf_poly_pkg::K; k++)
			w.coef[k] = gf_poly_pkg::coef_t'($urandom);
		return w;
	endfunction

	task automatic randomize_operands;
		for (int w = 0; w < gf_poly_pkg::DEPTH; w++) begin
			a_words[w] = random_word();
			b_words[w] = random_word();
		end
	endtask

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	task automatic check_word(input string name, input gf_poly_pkg::poly_word_u got,
		input gf_poly_pkg::poly_word_u exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got.flat, exp.flat);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	// ----------------------------------------------------------------------
	// host side drivers
	// ----------------------------------------------------------------------
	task automatic load_word(input int addr, input gf_poly_pkg::poly_word_u data);
		gf_poly_pkg::mem_req_t req;
		req.we = 1'b1;
		req.addr = gf_poly_pkg::addr_t'(addr);
		req.wdata = data;
		@(posedge clk);
		load <= req;
	endtask

	task automatic load_operands;
		for (int w = 0; w < gf_poly_pkg::DEPTH; w++) begin
			load_word(w, a_words[w]);
			load_word(gf_poly_pkg::DEPTH + w, b_words[w]); // B sits above A
		end
		@(posedge clk);
		load <= '0;
	endtask

	task automatic pulse_start;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_done;
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (!done && cnt < RUN_CYCLES + 10) begin
			@(negedge clk);
			cnt++;
		end
		if (!done) begin
			errors++;
			$display("done did not arrive within %0d cycles of start", RUN_CYCLES + 10);
		end else begin
			check_bit("busy", busy, 1'b0); // falls with done
		end
	endtask

	task automatic read_word(input int addr, output gf_poly_pkg::poly_word_u data);
		@(posedge clk);
		rd_addr <= gf_poly_pkg::addr_t'(addr);
		@(posedge clk);
		@(negedge clk);
		data = rd_data;
	endtask

	task automatic check_result;
		gf_poly_pkg::poly_word_u got;
		for (int w = 0; w < gf_poly_pkg::RAM_WORDS; w++) begin
			read_word(w, got);
			check_word($sformatf("rd_data c[%0d]", w), got, c_model[w]);
		end
	endtask

	task automatic run_product;
		load_operands;
		pulse_start;
		wait_done;
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic test_reset_idle;
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);
		repeat (20) begin
			@(negedge clk);
			if (done) begin
				errors++;
				$display("done pulsed while idle with no start");
			end
		end
	endtask

	task automatic test_identity;
		randomize_operands;
		for (int w = 0; w < gf_poly_pkg::DEPTH; w++)
			a_words[w] = '0;
		a_words[0].coef[0] = 8'h01;
		for (int w = 0; w < gf_poly_pkg::RAM_WORDS; w++)
			c_model[w] = (w < gf_poly_pkg::DEPTH) ? b_words[w] : '0; // C = B
		run_product;
		check_result;
	endtask

	task automatic test_zero_operand;
		randomize_operands;
		for (int w = 0; w < gf_poly_pkg::DEPTH; w++)
			a_words[w] = '0;
		for (int w = 0; w < gf_poly_pkg::RAM_WORDS; w++)
			c_model[w] = '0;
		run_product;
		check_result;
	endtask

	task automatic test_random(input int runs);
		for (int r = 0; r < runs; r++) begin
			randomize_operands;
			model_product;
			run_product;
			check_result;
		end
	endtask

	task automatic test_back_to_back;
		randomize_operands;
		run_product; // leaves a nonzero C behind
		randomize_operands;
		model_product;
		run_product;
		check_result;
	endtask

	task automatic test_busy_gating;
		gf_poly_pkg::mem_req_t bogus;
		int                    done_cnt;
		randomize_operands;
		model_product;
		load_operands;
		pulse_start;
		repeat (3) @(negedge clk);
		check_bit("busy", busy, 1'b1);
		bogus.we = 1'b1;
		bogus.addr = '0;
		bogus.wdata = random_word();
		@(posedge clk);
		start <= 1'b1;
		load <= bogus; // would overwrite A word 0
		@(posedge clk);
		start <= 1'b0;
		load <= '0;
		done_cnt = 0;
		repeat (2 * RUN_CYCLES) begin
			@(negedge clk);
			if (done)
				done_cnt++;
		end
		if (done_cnt != 1) begin
			errors++;
			$display("done pulsed %0d times for a single start", done_cnt);
		end
		check_bit("busy", busy, 1'b0);
		check_result;
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		void'($urandom(32'hbeab));
		errors = 0;
		checks = 0;
		rst_b = 1'b0;
		start = 1'b0;
		load = '0;
		rd_addr = '0;
		repeat (10) @(posedge clk);
		rst_b <= 1'b1;
		@(negedge clk);

		test_reset_idle;
		test_identity;
		test_zero_operand;
		test_random(3);
		test_back_to_back;
		test_busy_gating;

		repeat (2) @(posedge clk);
		errors += u_dut.u_asserts.fail_cnt;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_poly_mul_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module tb_poly_mul_asserts (
	input wire clk,
	input wire rst_b,
	input wire busy,
	input wire done
);

	int fail_cnt = 0; // read back by the testbench

	// done is a single-cycle pulse
	a_done_single: assert property (@(posedge clk) disable iff (!rst_b) done |=> !done)
		else begin
			$error("done high two cycles running");
			fail_cnt++;
		end

	// a run was in progress the cycle before done
	a_done_after_busy: assert property (@(posedge clk) disable iff (!rst_b)
		done |-> $past(busy))
		else begin
			$error("done without busy in the previous cycle");
			fail_cnt++;
		end

	a_idle_after_reset: assert property (@(posedge clk) $rose(rst_b) |-> !busy)
		else begin
			$error("busy high in the first cycle after reset");
			fail_cnt++;
		end

endmodule

`default_nettype wire

//--- verilog.f
gf_poly_pkg.sv
gf_mul.sv
word_mul.sv
word_ram.sv
mul_ctrl.sv
poly_mul_top.sv
tb_poly_mul_asserts.sv
tb_poly_mul.sv

//--- word_mul.sv
`timescale 1ns/10ps
`default_nettype none

module word_mul (
	input  wire                          clk,
	input  wire gf_poly_pkg::poly_word_u a,
	input  wire gf_poly_pkg::poly_word_u b,
	output gf_poly_pkg::prod_t           prod
);

	// pp[u][v] = a coef u times b coef v
	gf_poly_pkg::coef_t pp [gf_poly_pkg::K][gf_poly_pkg::K];

	// degree sums 0 .. 2K-2, top slot stays zero
	gf_poly_pkg::coef_t [2*gf_poly_pkg::K-1:0] fold;

	// ----------------------------------------------------------------------
	// K x K multiplier grid
	// ----------------------------------------------------------------------
	for (genvar gu = 0; gu < gf_poly_pkg::K; gu++) begin : g_row
		for (genvar gv = 0; gv < gf_poly_pkg::K; gv++) begin : g_col
			gf_mul u_gf_mul (
				.a (a.coef[gu]),
				.b (b.coef[gv]),
				.p (pp[gu][gv])
			);
		end
	end

	// ----------------------------------------------------------------------
	// column sums by output degree
	// ----------------------------------------------------------------------
	always_comb begin
		fold = '0;
		for (int u = 0; u < gf_poly_pkg::K; u++) begin
			for (int v = 0; v < gf_poly_pkg::K; v++) begin
				fold[u + v] = fold[u + v] ^ pp[u][v]; // degree u+v
			end
		end
	end

	// low K degrees stay in this word, the rest carry to the next word
	always_ff @(posedge clk) begin
		prod.lo.coef <= fold[gf_poly_pkg::K-1:0];
		prod.hi.coef <= fold[2*gf_poly_pkg::K-1:gf_poly_pkg::K];
	end

endmodule

`default_nettype wire

//--- word_ram.sv
`timescale 1ns/10ps
`default_nettype none

module word_ram (
	input  wire                          clk,
	input  wire gf_poly_pkg::mem_req_t   port_a,
	input  wire gf_poly_pkg::mem_req_t   port_b,
	output gf_poly_pkg::poly_word_u      rdata_a,
	output gf_poly_pkg::poly_word_u      rdata_b
);

	gf_poly_pkg::poly_word_u mem [gf_poly_pkg::RAM_WORDS];

	// ----------------------------------------------------------------------
	// write side, both ports may write in one cycle
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (port_a.we)
			mem[port_a.addr] <= port_a.wdata;
		if (port_b.we)
			mem[port_b.addr] <= port_b.wdata;
	end

	// ----------------------------------------------------------------------
	// read side
	// ----------------------------------------------------------------------
	// registered read, a write to the same address shows up a cycle later
	always_ff @(posedge clk) begin
		rdata_a <= mem[port_a.addr];
		rdata_b <= mem[port_b.addr];
	end

endmodule

`default_nettype wire
